// ==== source/dsp_pkg.sv ====
// DSP slice package with operand widths, mode encodings and shift constants
package dsp_pkg;

   localparam int a_w    = 30;
   localparam int b_w    = 18;
   localparam int d_w    = 25;
   localparam int c_w    = 48;
   localparam int prod_w = d_w + b_w;

   // Arithmetic right shift used by the shifted Z modes
   localparam int shift_amt = 17;

   typedef logic [a_w-1:0]    a_t;
   typedef logic [b_w-1:0]    b_t;
   typedef logic [d_w-1:0]    d_t;
   typedef logic [c_w-1:0]    c_t;
   typedef logic [prod_w-1:0] prod_t;

   // Bits 1:0 X select, bits 3:2 Y select, bits 6:4 Z select
   typedef logic [6:0] opmode_t;

   // Bit 1 zeroes A, bit 2 enables D, bit 3 subtracts A, bit 4 picks B1
   typedef logic [4:0] inmode_t;

   typedef enum logic [3:0] {
      alu_add      = 4'd0,
      alu_znot_add = 4'd1,
      alu_not_all  = 4'd2,
      alu_sub      = 4'd3
   } alumode_e;

   typedef enum logic [1:0] {x_zero, x_m, x_p, x_ab} xsel_e;

   typedef enum logic [1:0] {y_zero, y_m, y_ones, y_c} ysel_e;

   // Code 7 is undefined
   typedef enum logic [2:0] {
      z_zero, z_pcin, z_p, z_c, z_p2, z_pcin_shr, z_p_shr
   } zsel_e;

   // Same codes as the 7-series CARRYINSEL field where one exists
   typedef enum logic [2:0] {
      cin_ext    = 3'b000,
      cin_zero   = 3'b010,
      cin_p_sign = 3'b101
   } carrysel_e;

endpackage

// ==== source/dsp_ctrl_regs.sv ====
// Control register block holding opmode, alumode, inmode and carry-in select
module dsp_ctrl_regs import dsp_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      ce_ctrl,
   input  logic      ce_alumode,
   input  logic      ce_inmode,
   input  opmode_t   opmode,
   input  logic [3:0] alumode,
   input  inmode_t   inmode,
   input  logic [2:0] carryinsel,
   output opmode_t   opmode_q,
   output alumode_e  alumode_q,
   output inmode_t   inmode_q,
   output carrysel_e carrysel_q
);

   alumode_e  alumode_dec;
   carrysel_e carrysel_dec;

   // Logic ALU modes and other unsupported codes fall back to a plain add
   always_comb begin
      case (alumode)
         4'd0:    alumode_dec = alu_add;
         4'd1:    alumode_dec = alu_znot_add;
         4'd2:    alumode_dec = alu_not_all;
         4'd3:    alumode_dec = alu_sub;
         default: alumode_dec = alu_add;
      endcase
   end

   // Cascade carry sources do not exist here, so they read as zero
   always_comb begin
      case (carryinsel)
         3'b000:  carrysel_dec = cin_ext;
         3'b101:  carrysel_dec = cin_p_sign;
         default: carrysel_dec = cin_zero;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         opmode_q   <= '0;
         alumode_q  <= alu_add;
         inmode_q   <= '0;
         carrysel_q <= cin_ext;
      end else begin
         // Opmode and carry select share one enable
         if (ce_ctrl) begin
            opmode_q   <= opmode;
            carrysel_q <= carrysel_dec;
         end
         if (ce_alumode)
            alumode_q <= alumode_dec;
         if (ce_inmode)
            inmode_q <= inmode;
      end
   end

endmodule

// ==== source/dsp_preadder.sv ====
// A and D input registers with the D+/-A preadder and the AD register
module dsp_preadder import dsp_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    ce_a,
   input  logic    ce_d,
   input  logic    ce_ad,
   input  a_t      a,
   input  d_t      d,
   input  inmode_t inmode_q,
   output a_t      a_q,
   output d_t      ad_q
);

   d_t d_q;
   d_t a_pre;
   d_t d_pre;
   d_t ad_sum;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         a_q <= '0;
         d_q <= '0;
      end else begin
         if (ce_a)
            a_q <= a;
         if (ce_d)
            d_q <= d;
      end
   end

   // Only the low 25 bits of A reach the preadder
   assign a_pre = inmode_q[1] ? '0 : a_q[d_w-1:0];
   assign d_pre = inmode_q[2] ? d_q : '0;

   always_comb begin
      if (inmode_q[3])
         ad_sum = d_pre - a_pre;
      else
         ad_sum = d_pre + a_pre;
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         ad_q <= '0;
      else if (ce_ad)
         ad_q <= ad_sum;
   end

endmodule

// ==== source/dsp_b_pipe.sv ====
// Two-stage B input register with the multiplier operand stage select
module dsp_b_pipe import dsp_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    ce_b1,
   input  logic    ce_b2,
   input  b_t      b,
   input  inmode_t inmode_q,
   output b_t      b2_q,
   output b_t      b_mult
);

   b_t b1_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         b1_q <= '0;
         b2_q <= '0;
      end else begin
         if (ce_b1)
            b1_q <= b;
         if (ce_b2)
            b2_q <= b1_q;
      end
   end

   // B2 lines up with the AD register, B1 arrives one cycle early
   assign b_mult = inmode_q[4] ? b1_q : b2_q;

endmodule

// ==== source/dsp_mult.sv ====
// Signed 25x18 multiplier feeding the M register
module dsp_mult import dsp_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  ce_m,
   input  d_t    ad_q,
   input  b_t    b_mult,
   output prod_t m_q
);

   prod_t prod;

   // Full-width signed product, no partial split
   assign prod = prod_t'($signed(ad_q) * $signed(b_mult));

   always_ff @(posedge clk) begin
      if (!rst_n)
         m_q <= '0;
      else if (ce_m)
         m_q <= prod;
   end

endmodule

// ==== source/dsp_alu.sv ====
// Output stage with C register, X/Y/Z selectors, arithmetic ALU and P register
module dsp_alu import dsp_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      ce_c,
   input  logic      ce_p,
   input  c_t        c,
   input  c_t        pcin,
   input  c_t        ab,
   input  prod_t     m_q,
   input  opmode_t   opmode_q,
   input  alumode_e  alumode_q,
   input  carrysel_e carrysel_q,
   input  logic      carryin,
   output c_t        p,
   output logic      carryout
);

   c_t          c_q;
   xsel_e       xsel;
   ysel_e       ysel;
   zsel_e       zsel;
   c_t          x_op;
   c_t          y_op;
   c_t          z_op;
   c_t          z_in;
   logic        cin;
   logic [c_w:0] sum;
   c_t          result;

   always_ff @(posedge clk) begin
      if (!rst_n)
         c_q <= '0;
      else if (ce_c)
         c_q <= c;
   end

   assign xsel = xsel_e'(opmode_q[1:0]);
   assign ysel = ysel_e'(opmode_q[3:2]);
   assign zsel = zsel_e'(opmode_q[6:4]);

   always_comb begin
      case (xsel)
         x_m:     x_op = c_t'($signed(m_q));
         x_p:     x_op = p;
         x_ab:    x_op = ab;
         default: x_op = '0;
      endcase
   end

   // The whole product goes through X, so Y's M input adds nothing
   always_comb begin
      case (ysel)
         y_ones:  y_op = '1;
         y_c:     y_op = c_q;
         default: y_op = '0;
      endcase
   end

   always_comb begin
      case (zsel)
         z_pcin:     z_op = pcin;
         z_p:        z_op = p;
         z_c:        z_op = c_q;
         z_p2:       z_op = p;
         z_pcin_shr: z_op = c_t'($signed(pcin) >>> shift_amt);
         z_p_shr:    z_op = c_t'($signed(p) >>> shift_amt);
         default:    z_op = '0;
      endcase
   end

   always_comb begin
      case (carrysel_q)
         cin_ext:    cin = carryin;
         cin_p_sign: cin = ~p[c_w-1];
         default:    cin = 1'b0;
      endcase
   end

   // Subtract is computed as ~(~Z + X + Y + CIN)
   assign z_in = (alumode_q == alu_znot_add || alumode_q == alu_sub) ? ~z_op : z_op;
   assign sum  = {1'b0, z_in} + {1'b0, x_op} + {1'b0, y_op} + {{c_w{1'b0}}, cin};

   assign result = (alumode_q == alu_not_all || alumode_q == alu_sub) ?
                   ~sum[c_w-1:0] : sum[c_w-1:0];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         p        <= '0;
         carryout <= 1'b0;
      end else if (ce_p) begin
         p        <= result;
         carryout <= sum[c_w];
      end
   end

endmodule

// ==== source/dsp_slice.sv ====
// Top of the pipelined multiply-accumulate DSP slice
module dsp_slice import dsp_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  a_t         a,
   input  b_t         b,
   input  c_t         c,
   input  d_t         d,
   input  c_t         pcin,
   input  logic       carryin,
   input  opmode_t    opmode,
   input  logic [3:0] alumode,
   input  inmode_t    inmode,
   input  logic [2:0] carryinsel,
   input  logic       ce_a,
   input  logic       ce_b1,
   input  logic       ce_b2,
   input  logic       ce_c,
   input  logic       ce_d,
   input  logic       ce_ad,
   input  logic       ce_m,
   input  logic       ce_p,
   input  logic       ce_ctrl,
   input  logic       ce_alumode,
   input  logic       ce_inmode,
   output c_t         p,
   output c_t         pcout,
   output logic       carryout
);

   opmode_t   opmode_q;
   alumode_e  alumode_q;
   inmode_t   inmode_q;
   carrysel_e carrysel_q;
   a_t        a_q;
   d_t        ad_q;
   b_t        b2_q;
   b_t        b_mult;
   prod_t     m_q;
   c_t        ab;

   dsp_ctrl_regs u_ctrl (
      .clk, .rst_n, .ce_ctrl, .ce_alumode, .ce_inmode,
      .opmode, .alumode, .inmode, .carryinsel,
      .opmode_q, .alumode_q, .inmode_q, .carrysel_q
   );

   dsp_preadder u_preadder (
      .clk, .rst_n, .ce_a, .ce_d, .ce_ad, .a, .d, .inmode_q, .a_q, .ad_q
   );

   dsp_b_pipe u_b_pipe (
      .clk, .rst_n, .ce_b1, .ce_b2, .b, .inmode_q, .b2_q, .b_mult
   );

   dsp_mult u_mult (.clk, .rst_n, .ce_m, .ad_q, .b_mult, .m_q);

   // A above B forms the 48-bit X operand
   assign ab = {a_q, b2_q};

   dsp_alu u_alu (
      .clk, .rst_n, .ce_c, .ce_p, .c, .pcin, .ab, .m_q,
      .opmode_q, .alumode_q, .carrysel_q, .carryin, .p, .carryout
   );

   assign pcout = p;

endmodule

// ==== dv/dsp_slice_checker.sv ====
// Bound assertions on operand select legality and register reset values
module dsp_slice_checker import dsp_pkg::*; (
   input logic    clk,
   input logic    rst_n,
   input opmode_t opmode_q,
   input c_t      p
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;

   // The product only passes through X and Y as a pair
   m_select_pair: assert property (@(posedge clk) disable iff (!rst_n)
      (opmode_q[1:0] == x_m) == (opmode_q[3:2] == y_m))
      else begin
         $error("X and Y disagree on selecting M");
         fail_cnt++;
      end

   p_reset_zero: assert property (@(posedge clk) !rst_n |=> p == '0)
      else begin
         $error("Register value is not zero after reset");
         fail_cnt++;
      end

   z_code_legal: assert property (@(posedge clk) disable iff (!rst_n)
      opmode_q[6:4] != 3'd7)
      else begin
         $error("Registered opmode holds the undefined Z code");
         fail_cnt++;
      end

endmodule

bind dsp_alu dsp_slice_checker u_chk (.clk, .rst_n, .opmode_q, .p);
// Control registers go through the reset check as one packed word
bind dsp_ctrl_regs dsp_slice_checker u_chk (
   .clk, .rst_n, .opmode_q,
   .p(c_t'({alumode_q, carrysel_q, inmode_q, opmode_q}))
);

// ==== dv/dsp_slice_tb.sv ====
// Testbench for the DSP slice with random stimulus and a cycle-accurate model
module dsp_slice_tb import dsp_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int len_reset  = 40;
   localparam int len_mult   = 200;
   localparam int len_accum  = 200;
   localparam int len_alu    = 300;
   localparam int len_casc   = 200;
   localparam int len_enable = 400;
   // Test lengths plus reset, pipeline drain and some slack
   localparam int cycle_limit = len_reset + len_mult + len_accum + len_alu + len_casc
                                + len_enable + 100;

   logic clk = 1'b0;
   logic rst_n;
   a_t a;
   b_t b;
   c_t c, pcin, p, pcout;
   d_t d;
   logic carryin, carryout;
   opmode_t opmode;
   logic [3:0] alumode;
   inmode_t inmode;
   logic [2:0] carryinsel;
   logic ce_a, ce_b1, ce_b2, ce_c, ce_d, ce_ad, ce_m, ce_p, ce_ctrl, ce_alumode, ce_inmode;

   // Model registers, one per DUT register
   opmode_t m_opm;
   logic [1:0] m_alu, m_csel;
   inmode_t m_inm;
   a_t m_a;
   d_t m_d, m_ad;
   b_t m_b1, m_b2;
   prod_t m_m;
   c_t m_c, m_p;
   logic m_co;

   integer seed = 1640;
   int err_cnt = 0;
   int chk_cnt = 0;
   int cycles = 0;
   int total;
   logic check_on = 1'b0;

   always #5 clk = ~clk;

   dsp_slice dut (.*);

   function automatic int pick(input int n);
      return {$random(seed)} % n;
   endfunction

   function automatic logic [63:0] rand64();
      return {$random(seed), $random(seed)};
   endfunction

   // X or Y code from zero, P/ones and AB/C, never M
   function automatic logic [1:0] pick_no_m();
      int k;
      k = pick(3);
      return (k == 0) ? 2'd0 : 2'(k + 1);
   endfunction

   task automatic compare(input string what, input c_t got, input c_t exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Error at %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic drive_cycle(input int kind);
      logic [63:0] r;
      logic [3:0] pre;
      logic [1:0] xs, ys;
      int k;
      @(posedge clk);
      r = rand64();
      a <= r[a_w-1:0];
      d <= r[a_w+d_w-1:a_w];
      r = rand64();
      b <= r[b_w-1:0];
      c <= r[63:16];
      r = rand64();
      pcin <= r[c_w-1:0];
      carryin <= r[63];
      // Preadder D+A, D-A or A alone, with B1 or B2 picked at random
      k = pick(3);
      pre = (k == 0) ? 4'b0100 : (k == 1) ? 4'b1100 : 4'b0000;
      inmode <= {1'(pick(2)), pre};
      alumode <= 4'd0;
      carryinsel <= 3'b010;
      {ce_a, ce_b1, ce_b2, ce_c, ce_d, ce_ad, ce_m, ce_p} <= '1;
      {ce_ctrl, ce_alumode, ce_inmode} <= '1;
      xs = pick_no_m();
      ys = pick_no_m();
      case (kind)
         0: begin
            opmode <= 7'b010_01_01;
            ce_p <= (pick(4) == 0);
         end
         1: opmode <= 7'b000_01_01;
         2: begin
            opmode <= 7'b010_01_01;
            carryinsel <= (pick(2) == 0) ? 3'b000 : 3'b010;
         end
         3: begin
            k = pick(4);
            opmode <= {(k == 0) ? 3'd0 : 3'(k + 1), ys, xs};
            alumode <= 4'(pick(16));
            carryinsel <= 3'(pick(8));
         end
         4: begin
            k = pick(3);
            opmode <= {(k == 0) ? 3'd1 : 3'(k + 4), ys, xs};
            alumode <= 4'(pick(4));
            carryinsel <= 3'(pick(8));
         end
         default: begin
            if (pick(3) == 0)
               opmode <= {3'(pick(7)), 2'd1, 2'd1};
            else
               opmode <= {3'(pick(7)), ys, xs};
            alumode <= 4'(pick(16));
            carryinsel <= 3'(pick(8));
            inmode <= 5'(pick(32));
            {ce_a, ce_b1, ce_b2, ce_c} <= {pick(4) != 0, pick(4) != 0, pick(4) != 0, pick(4) != 0};
            {ce_d, ce_ad, ce_m, ce_p} <= {pick(4) != 0, pick(4) != 0, pick(4) != 0, pick(4) != 0};
            {ce_ctrl, ce_alumode, ce_inmode} <= {pick(4) != 0, pick(4) != 0, pick(4) != 0};
         end
      endcase
   endtask

   task automatic run_test(input string name, input int kind, input int len);
      int start_err;
      start_err = err_cnt;
      repeat (len)
         drive_cycle(kind);
      $display("Test %s finished with %0d errors", name, err_cnt - start_err);
   endtask

   always @(posedge clk) begin : model
      logic [d_w-1:0] a_pre, d_pre, ad_next;
      logic signed [prod_w-1:0] prod;
      b_t b_sel;
      c_t xv, yv, zv, res;
      logic cin;
      logic [c_w:0] sum;
      a_pre = m_inm[1] ? '0 : m_a[d_w-1:0];
      d_pre = m_inm[2] ? m_d : '0;
      ad_next = m_inm[3] ? d_pre - a_pre : d_pre + a_pre;
      b_sel = m_inm[4] ? m_b1 : m_b2;
      prod = $signed(m_ad) * $signed(b_sel);
      case (m_opm[1:0])
         2'd1: xv = {{(c_w-prod_w){m_m[prod_w-1]}}, m_m};
         2'd2: xv = m_p;
         2'd3: xv = {m_a, m_b2};
         default: xv = '0;
      endcase
      yv = (m_opm[3:2] == 2'd2) ? '1 : (m_opm[3:2] == 2'd3) ? m_c : '0;
      case (m_opm[6:4])
         3'd1: zv = pcin;
         3'd2, 3'd4: zv = m_p;
         3'd3: zv = m_c;
         3'd5: zv = c_t'($signed(pcin) >>> shift_amt);
         3'd6: zv = c_t'($signed(m_p) >>> shift_amt);
         default: zv = '0;
      endcase
      cin = (m_csel == 2'd0) ? carryin : (m_csel == 2'd1) ? ~m_p[c_w-1] : 1'b0;
      // Modes 1 and 3 run an inverted Z through the carry chain
      sum = {1'b0, m_alu[0] ? ~zv : zv} + {1'b0, xv} + {1'b0, yv} + {{c_w{1'b0}}, cin};
      case (m_alu)
         2'd0: res = zv + xv + yv + c_t'(cin);
         2'd1: res = ~zv + xv + yv + c_t'(cin);
         2'd2: res = ~(zv + xv + yv + c_t'(cin));
         default: res = zv - (xv + yv + c_t'(cin));
      endcase
      if (!rst_n) begin
         {m_opm, m_alu, m_csel, m_inm, m_a, m_d, m_ad} <= '0;
         {m_b1, m_b2, m_m, m_c, m_p, m_co} <= '0;
      end else begin
         if (ce_ctrl) begin
            m_opm <= opmode;
            m_csel <= (carryinsel == 3'b000) ? 2'd0 : (carryinsel == 3'b101) ? 2'd1 : 2'd2;
         end
         if (ce_alumode)
            m_alu <= (alumode < 4'd4) ? alumode[1:0] : 2'd0;
         if (ce_inmode)
            m_inm <= inmode;
         if (ce_a)
            m_a <= a;
         if (ce_d)
            m_d <= d;
         if (ce_ad)
            m_ad <= ad_next;
         if (ce_b1)
            m_b1 <= b;
         if (ce_b2)
            m_b2 <= m_b1;
         if (ce_m)
            m_m <= prod;
         if (ce_c)
            m_c <= c;
         if (ce_p) begin
            m_p <= res;
            m_co <= sum[c_w];
         end
      end
   end

   // Outputs are compared half a cycle after the edge
   always @(negedge clk) begin
      if (check_on) begin
         compare("p", p, m_p);
         compare("pcout", pcout, m_p);
         compare("carryout", c_t'(carryout), c_t'(m_co));
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
         $display("TB FAILED");
         $finish;
      end
   end

   initial begin
      rst_n = 1'b0;
      {a, b, c, d, pcin, carryin, opmode, alumode, inmode, carryinsel} = '0;
      {ce_a, ce_b1, ce_b2, ce_c, ce_d, ce_ad, ce_m, ce_p, ce_ctrl, ce_alumode, ce_inmode} = '1;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      check_on <= 1'b1;
      @(negedge clk);
      compare("p after reset", p, '0);
      compare("carryout after reset", c_t'(carryout), '0);
      run_test("reset and P hold", 0, len_reset);
      run_test("multiply", 1, len_mult);
      run_test("accumulate", 2, len_accum);
      run_test("ALU modes", 3, len_alu);
      run_test("cascade", 4, len_casc);
      run_test("clock enables", 5, len_enable);
      repeat (6) @(posedge clk);
      total = err_cnt + dut.u_alu.u_chk.fail_cnt + dut.u_ctrl.u_chk.fail_cnt;
      $display("Summary: 6 tests, %0d checks, %0d errors, %0d assertion failures",
               chk_cnt, err_cnt, total - err_cnt);
      if (total == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== dsp_slice.f ====
source/dsp_pkg.sv
source/dsp_ctrl_regs.sv
source/dsp_preadder.sv
source/dsp_b_pipe.sv
source/dsp_mult.sv
source/dsp_alu.sv
source/dsp_slice.sv
dv/dsp_slice_checker.sv
dv/dsp_slice_tb.sv

// ==== Bender.yml ====
package:
  name: dsp_slice

sources:
  - files:
      - source/dsp_pkg.sv
      - source/dsp_ctrl_regs.sv
      - source/dsp_preadder.sv
      - source/dsp_b_pipe.sv
      - source/dsp_mult.sv
      - source/dsp_alu.sv
      - source/dsp_slice.sv
  - target: simulation
    files:
      - dv/dsp_slice_checker.sv
      - dv/dsp_slice_tb.sv
